//--- design/axi_lite_pkg.sv
//////////////////////////////////////////////////////////////////////
// AXI4-lite read channel widths, response codes and word types
// Shared by every block of the read traffic master
//////////////////////////////////////////////////////////////////////

package axi_lite_pkg;

    //////////////////////////////////////////////////////////////////////
    // Channel widths
    //////////////////////////////////////////////////////////////////////

    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int ID_W   = 8;

    //////////////////////////////////////////////////////////////////////
    // Response codes
    //////////////////////////////////////////////////////////////////////

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    // Returned by the interconnect when no slave decodes the address
    localparam logic [1:0] RESP_DECERR = 2'b11;

    //////////////////////////////////////////////////////////////////////
    // Word types
    //////////////////////////////////////////////////////////////////////

    typedef logic [ADDR_W-1:0] axi_addr_t;
    typedef logic [DATA_W-1:0] axi_data_t;
    typedef logic [ID_W-1:0]   axi_id_t;
    typedef logic [1:0]        axi_resp_t;

endpackage

//--- design/traffic_pkg.sv
//////////////////////////////////////////////////////////////////////
// Traffic rules of the read master: LFSR word decoding and the
// expected RDATA / RRESP that the slave model must return
//////////////////////////////////////////////////////////////////////

package traffic_pkg;

    // One LFSR step, seen either as a whole word or as two halves
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [15:0]             seed;
            axi_lite_pkg::axi_addr_t addr;
        } f;
    } lfsr_word_u;

    // Data pattern: address in the low half, its inverse above
    function automatic axi_lite_pkg::axi_data_t expected_rdata(
        input axi_lite_pkg::axi_addr_t addr
    );
        return {~addr, addr};
    endfunction

    // OKAY inside the slave window, decode error outside of it
    function automatic axi_lite_pkg::axi_resp_t expected_rresp(
        input axi_lite_pkg::axi_addr_t addr,
        input axi_lite_pkg::axi_addr_t slv_start,
        input axi_lite_pkg::axi_addr_t slv_end
    );
        if (addr >= slv_start && addr <= slv_end)
            return axi_lite_pkg::RESP_OKAY;
        return axi_lite_pkg::RESP_DECERR;
    endfunction

endpackage

//--- design/rd_master_ifs.sv
//////////////////////////////////////////////////////////////////////
// Internal links of the read master: request issue into the slot
// table, and completion lookup from the checker into the table
//////////////////////////////////////////////////////////////////////

interface ar_issue_if;
    import axi_lite_pkg::*;

    logic      issue;
    logic [2:0] slot;
    axi_id_t   id;
    axi_data_t exp_data;
    axi_resp_t exp_resp;
    logic      slot_busy;

    modport gen (output issue, slot, id, exp_data, exp_resp, input slot_busy);
    modport tbl (input issue, slot, id, exp_data, exp_resp, output slot_busy);
endinterface

interface or_lookup_if;
    import axi_lite_pkg::*;

    axi_id_t   rid;
    logic      hit;
    axi_data_t exp_data;
    axi_resp_t exp_resp;
    // Pulse on an R handshake that hits a live slot
    logic      retire;

    modport chk (output rid, retire, input hit, exp_data, exp_resp);
    modport tbl (input rid, retire, output hit, exp_data, exp_resp);
endinterface

//--- design/lfsr32.sv
//////////////////////////////////////////////////////////////////////
// 32-bit Galois LFSR, loaded with KEY on reset, one step per enable
//////////////////////////////////////////////////////////////////////

module lfsr32 #(
    parameter logic [31:0] KEY = 32'hFFFF_FFFF
) (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        en,
    output logic [31:0] lfsr
);

    // Taps of x^32 + x^22 + x^2 + x + 1, shifting towards bit 0
    localparam logic [31:0] TAPS = 32'h8020_0003;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            lfsr <= KEY;
        end else if (en) begin
            lfsr <= (lfsr >> 1) ^ ({32{lfsr[0]}} & TAPS);
        end
    end

endmodule

//--- design/ar_request_gen.sv
//////////////////////////////////////////////////////////////////////
// AR channel driver: random pacing, windowed addresses and rolling IDs
// Hands each accepted request to the slot table with its expectations
//////////////////////////////////////////////////////////////////////

module ar_request_gen #(
    parameter axi_lite_pkg::axi_id_t   MST_ID    = 8'h10,
    parameter int                      OSTD_NUM  = 4,
    parameter logic [31:0]             KEY       = 32'hFFFF_FFFF,
    parameter axi_lite_pkg::axi_addr_t SLV_START = 16'h0100,
    parameter axi_lite_pkg::axi_addr_t SLV_END   = 16'h0EFF
) (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  logic                    en,
    input  axi_lite_pkg::axi_addr_t addr_min,
    input  axi_lite_pkg::axi_addr_t addr_max,
    input  logic                    arready,
    output logic                    arvalid,
    output axi_lite_pkg::axi_addr_t araddr,
    output axi_lite_pkg::axi_id_t   arid,
    output logic [2:0]              arprot,
    ar_issue_if.gen                 issue
);
    import axi_lite_pkg::*;
    import traffic_pkg::*;

    logic        ar_hs;
    logic        ar_wait;
    logic [31:0] ar_lfsr;
    lfsr_word_u  ar_word;
    logic [31:0] pace;
    logic [2:0]  id_cnt;
    axi_addr_t   cand_addr;
    axi_addr_t   ramp_q;
    axi_addr_t   ramp_addr;
    axi_addr_t   min_aligned;
    logic [ADDR_W:0] ramp_next;

    assign ar_hs = arvalid & arready;

    // Steps only on a handshake so the request fields hold while waiting
    lfsr32 #(.KEY(KEY)) u_ar_lfsr (
        .aclk    (aclk),
        .aresetn (aresetn),
        .en      (ar_hs),
        .lfsr    (ar_lfsr)
    );

    assign ar_word.raw = ar_lfsr;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            pace    <= '0;
            id_cnt  <= '0;
            ramp_q  <= '0;
            ar_wait <= 1'b0;
        end else begin
            // A raised request stays up until the slave accepts it
            ar_wait <= arvalid & ~arready;
            if (pace == '0 || ar_hs)
                pace <= ar_word.raw;
            else if (!arvalid)
                pace <= pace >> 1;
            if (ar_hs) begin
                id_cnt <= (id_cnt == 3'(OSTD_NUM - 1)) ? 3'd0 : id_cnt + 3'd1;
                ramp_q <= (ramp_next > {1'b0, addr_max}) ? min_aligned
                                                          : ramp_next[ADDR_W-1:0];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Address selection
    //////////////////////////////////////////////////////////////////////

    assign min_aligned = {addr_min[ADDR_W-1:2], 2'b00};
    assign cand_addr   = {ar_word.f.addr[ADDR_W-1:2], 2'b00};
    // Ramp restarts from the window base whenever it sits outside it
    assign ramp_addr   = (ramp_q < addr_min || ramp_q > addr_max) ? min_aligned : ramp_q;
    assign ramp_next   = {1'b0, ramp_addr} + (ADDR_W + 1)'(4);

    assign araddr  = (cand_addr >= addr_min && cand_addr <= addr_max) ? cand_addr : ramp_addr;
    assign arid    = MST_ID + axi_id_t'(id_cnt);
    assign arprot  = 3'b000;
    assign arvalid = ar_wait | (pace[0] & en & ~issue.slot_busy);

    assign issue.issue    = ar_hs;
    assign issue.slot     = id_cnt;
    assign issue.id       = arid;
    assign issue.exp_data = expected_rdata(araddr);
    assign issue.exp_resp = expected_rresp(araddr, SLV_START, SLV_END);

    // A stalled request keeps its fields until the slave takes it
    ar_hold_a: assert property (@(posedge aclk) disable iff (!aresetn)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arid))
        else $error("AR request changed while stalled");

endmodule

//--- design/rd_or_table.sv
//////////////////////////////////////////////////////////////////////
// Outstanding read slots: expected completion per ID and its age
// Filled on AR handshake, freed when the checker retires the slot
//////////////////////////////////////////////////////////////////////

module rd_or_table #(
    parameter int OSTD_NUM = 4,
    parameter int TIMEOUT  = 100
) (
    input  logic    aclk,
    input  logic    aresetn,
    ar_issue_if.tbl issue,
    or_lookup_if.tbl lookup,
    output logic    or_timeout
);
    import axi_lite_pkg::*;

    localparam int AGE_W = $clog2(TIMEOUT + 1);

    logic [OSTD_NUM-1:0] busy;
    logic [OSTD_NUM-1:0] issue_sel;
    logic [OSTD_NUM-1:0] hit_vec;
    logic [AGE_W-1:0]    age [OSTD_NUM];
    axi_id_t             slot_id [OSTD_NUM];
    axi_data_t           slot_data [OSTD_NUM];
    axi_resp_t           slot_resp [OSTD_NUM];

    // Slot decode, lookup by ID and timeout detection
    always_comb begin
        lookup.exp_data = '0;
        lookup.exp_resp = RESP_OKAY;
        or_timeout      = 1'b0;
        for (int i = 0; i < OSTD_NUM; i++) begin
            issue_sel[i] = (issue.slot == 3'(i));
            hit_vec[i]   = busy[i] && (slot_id[i] == lookup.rid);
            if (hit_vec[i]) begin
                lookup.exp_data = slot_data[i];
                lookup.exp_resp = slot_resp[i];
            end
            if (busy[i] && age[i] == AGE_W'(TIMEOUT))
                or_timeout = 1'b1;
        end
    end

    assign lookup.hit      = |hit_vec;
    assign issue.slot_busy = |(busy & issue_sel);

    //////////////////////////////////////////////////////////////////////
    // Slot state
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            busy <= '0;
            for (int i = 0; i < OSTD_NUM; i++)
                age[i] <= '0;
        end else begin
            for (int i = 0; i < OSTD_NUM; i++) begin
                if (issue.issue && issue_sel[i]) begin
                    busy[i] <= 1'b1;
                    age[i]  <= '0;
                end else if (lookup.retire && hit_vec[i]) begin
                    busy[i] <= 1'b0;
                    age[i]  <= '0;
                end else if (busy[i] && age[i] != AGE_W'(TIMEOUT)) begin
                    // Saturates once the deadline is reached
                    age[i] <= age[i] + AGE_W'(1);
                end
            end
        end
    end

    // Expectations captured with the request
    always_ff @(posedge aclk) begin
        for (int i = 0; i < OSTD_NUM; i++) begin
            if (issue.issue && issue_sel[i]) begin
                slot_id[i]   <= issue.id;
                slot_data[i] <= issue.exp_data;
                slot_resp[i] <= issue.exp_resp;
            end
        end
    end

    // The request side must never overwrite a live slot
    issue_free_a: assert property (@(posedge aclk) disable iff (!aresetn)
        issue.issue |-> (busy & issue_sel) == '0)
        else $error("AR issued into a busy slot");

endmodule

//--- design/r_completion_checker.sv
//////////////////////////////////////////////////////////////////////
// R channel side: random RREADY, completion checks and sticky error
//////////////////////////////////////////////////////////////////////

module r_completion_checker #(
    parameter axi_lite_pkg::axi_id_t MST_ID = 8'h10,
    parameter logic [31:0]           KEY    = 32'hFFFF_FFFF
) (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  logic                    en,
    input  logic                    rvalid,
    output logic                    rready,
    input  axi_lite_pkg::axi_id_t   rid,
    input  axi_lite_pkg::axi_data_t rdata,
    input  axi_lite_pkg::axi_resp_t rresp,
    input  logic                    or_timeout,
    or_lookup_if.chk                lookup,
    output logic                    error
);
    import axi_lite_pkg::*;

    // Half-word rotation keeps R pacing apart from AR pacing
    localparam logic [31:0] R_KEY = {KEY[15:0], KEY[31:16]};

    logic [31:0] r_lfsr;
    logic [31:0] pace;
    logic        reload;
    logic        r_hs;
    logic        bad_cmpl;
    logic        error_q;

    // Pacing word drains one bit per cycle, then takes a fresh LFSR step
    assign reload = (pace[31:1] == '0);

    lfsr32 #(.KEY(R_KEY)) u_r_lfsr (
        .aclk    (aclk),
        .aresetn (aresetn),
        .en      (reload),
        .lfsr    (r_lfsr)
    );

    assign rready = pace[0];
    assign r_hs   = rvalid & rready;

    assign lookup.rid    = rid;
    assign lookup.retire = r_hs & lookup.hit;

    // ID must carry the master bits, hit a slot and match its expectations
    assign bad_cmpl = ((rid & MST_ID) != MST_ID) || !lookup.hit
                      || (rdata != lookup.exp_data) || (rresp != lookup.exp_resp);

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            pace    <= '0;
            error_q <= 1'b0;
        end else begin
            pace <= reload ? r_lfsr : pace >> 1;
            if ((r_hs && bad_cmpl) || or_timeout)
                error_q <= 1'b1;
        end
    end

    assign error = error_q & en;

endmodule

//--- design/rd_traffic_master.sv
//////////////////////////////////////////////////////////////////////
// AXI4-lite read traffic master: random reads, checked completions
//////////////////////////////////////////////////////////////////////

module rd_traffic_master #(
    parameter axi_lite_pkg::axi_id_t   MST_ID    = 8'h10,
    parameter int                      OSTD_NUM  = 4,
    parameter int                      TIMEOUT   = 100,
    parameter logic [31:0]             KEY       = 32'h5A3C_96E1,
    parameter axi_lite_pkg::axi_addr_t SLV_START = 16'h0100,
    parameter axi_lite_pkg::axi_addr_t SLV_END   = 16'h0EFF
) (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  logic                    en,
    input  axi_lite_pkg::axi_addr_t addr_min,
    input  axi_lite_pkg::axi_addr_t addr_max,
    output logic                    arvalid,
    input  logic                    arready,
    output axi_lite_pkg::axi_addr_t araddr,
    output axi_lite_pkg::axi_id_t   arid,
    output logic [2:0]              arprot,
    input  logic                    rvalid,
    output logic                    rready,
    input  axi_lite_pkg::axi_id_t   rid,
    input  axi_lite_pkg::axi_data_t rdata,
    input  axi_lite_pkg::axi_resp_t rresp,
    output logic                    error
);

    logic or_timeout;

    ar_issue_if  issue_bus ();
    or_lookup_if lookup_bus ();

    ar_request_gen #(
        .MST_ID    (MST_ID),
        .OSTD_NUM  (OSTD_NUM),
        .KEY       (KEY),
        .SLV_START (SLV_START),
        .SLV_END   (SLV_END)
    ) u_ar_gen (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .en       (en),
        .addr_min (addr_min),
        .addr_max (addr_max),
        .arready  (arready),
        .arvalid  (arvalid),
        .araddr   (araddr),
        .arid     (arid),
        .arprot   (arprot),
        .issue    (issue_bus)
    );

    rd_or_table #(
        .OSTD_NUM (OSTD_NUM),
        .TIMEOUT  (TIMEOUT)
    ) u_or_table (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .issue      (issue_bus),
        .lookup     (lookup_bus),
        .or_timeout (or_timeout)
    );

    r_completion_checker #(
        .MST_ID (MST_ID),
        .KEY    (KEY)
    ) u_r_checker (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .en         (en),
        .rvalid     (rvalid),
        .rready     (rready),
        .rid        (rid),
        .rdata      (rdata),
        .rresp      (rresp),
        .or_timeout (or_timeout),
        .lookup     (lookup_bus),
        .error      (error)
    );

endmodule

//--- sim/tb_rd_traffic_master.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the read traffic master: AXI4-lite slave model with
// fault injection, driven test by test from the stimulus file
//////////////////////////////////////////////////////////////////////

module tb_rd_traffic_master;

    localparam logic [7:0]  MST_ID    = 8'h10;
    localparam int          OSTD_NUM  = 4;
    localparam int          TIMEOUT   = 100;
    localparam logic [31:0] KEY       = 32'h5A3C_96E1;
    localparam logic [15:0] SLV_START = 16'h0100;
    localparam logic [15:0] SLV_END   = 16'h0EFF;
    localparam logic [31:0] SEED      = 32'h84c65bd2;
    localparam int          MAX_TESTS = 32;
    localparam int          NEVER     = 32'h7FFF_FFFF;

    logic        aclk;
    logic        aresetn;
    logic        en;
    logic [15:0] addr_min;
    logic [15:0] addr_max;
    logic        arvalid;
    logic        arready = 1'b0;
    logic [15:0] araddr;
    logic [7:0]  arid;
    logic [2:0]  arprot;
    logic        rvalid = 1'b0;
    logic        rready;
    logic [7:0]  rid = 8'h00;
    logic [31:0] rdata = 32'h0;
    logic [1:0]  rresp = 2'b00;
    logic        error;

    logic [31:0] stim [0:MAX_TESTS*5];
    int          cyc = 0;
    int          limit = NEVER;
    int          errors = 0;
    int          cur_fault = 0;
    int          served;
    int          accepted;
    int          presented;
    int          outstanding;
    int          expect_at;
    bit          armed;
    bit          err_seen;
    bit          first_cycle;
    bit          stall;
    bit          beat_bad;
    logic [15:0] stall_addr;
    logic [7:0]  stall_id;
    logic [7:0]  exp_id;
    logic [15:0] q_addr [$];
    logic [7:0]  q_id [$];
    int          q_due [$];

    rd_traffic_master #(
        .MST_ID    (MST_ID),
        .OSTD_NUM  (OSTD_NUM),
        .TIMEOUT   (TIMEOUT),
        .KEY       (KEY),
        .SLV_START (SLV_START),
        .SLV_END   (SLV_END)
    ) dut (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .en       (en),
        .addr_min (addr_min),
        .addr_max (addr_max),
        .arvalid  (arvalid),
        .arready  (arready),
        .araddr   (araddr),
        .arid     (arid),
        .arprot   (arprot),
        .rvalid   (rvalid),
        .rready   (rready),
        .rid      (rid),
        .rdata    (rdata),
        .rresp    (rresp),
        .error    (error)
    );

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    //////////////////////////////////////////////////////////////////////
    // Slave data rules and reporting
    //////////////////////////////////////////////////////////////////////

    // Address in the low half, its inverse in the high half
    function automatic logic [31:0] read_pattern(input logic [15:0] addr);
        return {~addr, addr};
    endfunction

    function automatic logic [1:0] window_resp(input logic [15:0] addr);
        if (addr >= SLV_START && addr <= SLV_END)
            return 2'b00;
        return 2'b11;
    endfunction

    task automatic report_value(input string sig, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("ERROR at %0t: %s = %0h, expected %0h", $time, sig, got, exp);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("FAILURE at %0t: %s", $time, what);
        errors++;
    endtask

    task automatic check_quiet_outputs();
        if (arvalid !== 1'b0) report_value("arvalid", 32'(arvalid), 0);
        if (rready !== 1'b0) report_value("rready", 32'(rready), 0);
        if (error !== 1'b0) report_value("error", 32'(error), 0);
    endtask

    // Sticky error may only rise once a fault is armed, and then in time
    task automatic check_error_output();
        if (error === 1'b1) begin
            if (!armed) begin
                report_value("error", 32'(error), 0);
                armed = 1'b1;
                expect_at = NEVER;
            end
            err_seen = 1'b1;
        end else if (err_seen) begin
            report_value("error", 32'(error), 1);
            err_seen = 1'b0;
        end else if (armed && cyc >= expect_at) begin
            report_value("error", 32'(error), 1);
            expect_at = NEVER;
        end
    endtask

    task automatic check_request();
        if (araddr[1:0] !== 2'b00) report_value("araddr[1:0]", 32'(araddr[1:0]), 0);
        if (araddr < addr_min || araddr > addr_max)
            report_failure($sformatf("araddr %h lies outside the window %h..%h",
                                     araddr, addr_min, addr_max));
        if (arid !== exp_id) report_value("arid", 32'(arid), 32'(exp_id));
        if (arprot !== 3'b000) report_value("arprot", 32'(arprot), 0);
        exp_id = (exp_id == MST_ID + 8'(OSTD_NUM - 1)) ? MST_ID : exp_id + 8'd1;
        outstanding++;
        if (outstanding > OSTD_NUM)
            report_failure($sformatf("%0d reads outstanding at the slave, limit is %0d",
                                     outstanding, OSTD_NUM));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Slave model and monitor
    //////////////////////////////////////////////////////////////////////

    always @(posedge aclk) begin
        arready <= ($urandom % 32'd4) != 32'd0;
        if (!aresetn) begin
            check_quiet_outputs();
            rvalid <= 1'b0;
            q_addr.delete();
            q_id.delete();
            q_due.delete();
            served = 0;
            accepted = 0;
            presented = 0;
            outstanding = 0;
            expect_at = NEVER;
            armed = 1'b0;
            err_seen = 1'b0;
            beat_bad = 1'b0;
            stall = 1'b0;
            first_cycle = 1'b1;
            exp_id = MST_ID;
        end else if (first_cycle) begin
            check_quiet_outputs();
            first_cycle = 1'b0;
        end else begin
            check_error_output();
            // A stalled request must hold its fields
            if (stall) begin
                if (arvalid !== 1'b1)
                    report_value("arvalid", 32'(arvalid), 1);
                if (araddr !== stall_addr)
                    report_value("araddr", 32'(araddr), 32'(stall_addr));
                if (arid !== stall_id)
                    report_value("arid", 32'(arid), 32'(stall_id));
            end
            if (rvalid && rready) begin
                served++;
                outstanding--;
                rvalid <= 1'b0;
                if (beat_bad) begin
                    armed = 1'b1;
                    expect_at = cyc + 1;
                end
            end
            if (arvalid && arready) begin
                check_request();
                q_addr.push_back(araddr);
                q_id.push_back(arid);
                q_due.push_back(cyc + int'($urandom % 32'd8));
                if (cur_fault == 4 && accepted == 0) begin
                    armed = 1'b1;
                    expect_at = cyc + TIMEOUT + 2;
                end
                accepted++;
            end
            stall = arvalid && !arready;
            stall_addr = araddr;
            stall_id = arid;
            // Next response once its delay has run out
            if ((!rvalid || rready) && q_due.size() > 0 && q_due[0] <= cyc) begin
                presented++;
                if (!(cur_fault == 4 && presented == 1)) begin
                    rvalid <= 1'b1;
                    rid <= q_id[0];
                    rdata <= read_pattern(q_addr[0]);
                    rresp <= window_resp(q_addr[0]);
                    beat_bad = (presented == 1) && (cur_fault >= 1 && cur_fault <= 3);
                    if (presented == 1 && cur_fault == 1)
                        rdata <= read_pattern(q_addr[0]) ^ 32'h1;
                    if (presented == 1 && cur_fault == 2)
                        rresp <= window_resp(q_addr[0]) ^ 2'b11;
                    if (presented == 1 && cur_fault == 3)
                        rid <= q_id[0] & ~MST_ID;
                end
                q_addr.delete(0);
                q_id.delete(0);
                q_due.delete(0);
            end
        end
        cyc++;
        if (cyc >= limit) begin
            $display("Run stopped: tests did not finish within %0d cycles", limit);
            $display("Something failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequencer
    //////////////////////////////////////////////////////////////////////

    initial begin
        int          n_tests;
        int          t;
        int          k;
        int          fault;
        int          n_resp;
        int          total;
        int          n_withheld;
        int          failed;
        int          err_before;
        logic        exp_err;

        aresetn = 1'b0;
        en = 1'b0;
        addr_min = 16'h0000;
        addr_max = 16'h0000;
        void'($urandom(SEED));
        $readmemh("sim/rd_stimulus.dat", stim);
        n_tests = int'(stim[0]);
        total = 0;
        n_withheld = 0;
        for (t = 0; t < n_tests; t++) begin
            total += int'(stim[1 + 5*t + 3]);
            if (stim[1 + 5*t + 2] == 32'd4)
                n_withheld++;
        end
        limit = total * 16 + 50 * n_tests + TIMEOUT * n_withheld;
        failed = 0;

        for (t = 0; t < n_tests; t++) begin
            k = 1 + 5*t;
            fault = int'(stim[k+2]);
            n_resp = int'(stim[k+3]);
            exp_err = stim[k+4][0];
            err_before = errors;
            @(posedge aclk);
            aresetn <= 1'b0;
            en <= 1'b1;
            addr_min <= stim[k][15:0];
            addr_max <= stim[k+1][15:0];
            @(negedge aclk);
            cur_fault = fault;
            repeat (10) @(posedge aclk);
            aresetn <= 1'b1;
            @(negedge aclk);
            while (served < n_resp || (fault == 4 && !err_seen))
                @(negedge aclk);
            repeat (3) @(negedge aclk);
            if (error !== exp_err) report_value("error", 32'(error), 32'(exp_err));
            if (errors != err_before) failed++;
            $display("test %0d: window %h..%h, fault %0d, %0d responses, error %b, %s",
                     t, stim[k][15:0], stim[k+1][15:0], fault, n_resp, error,
                     (errors == err_before) ? "passed" : "FAILED");
        end

        $display("%0d tests run, %0d failed, %0d check errors", n_tests, failed, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

//--- sim/rd_stimulus.dat
// First word: number of tests. Then one test per line, all hex:
// addr_min addr_max fault(0 none,1 data,2 resp,3 rid,4 withhold) responses expected_error
0C
0100 0EFF 0 14 0
0000 00FF 0 14 0
0E00 0FFF 0 14 0
0200 021F 0 10 0
0000 FFFF 0 18 0
0300 0303 0 08 0
0100 0EFF 1 06 1
0F00 1FFF 2 06 1
0040 013F 2 04 1
0800 08FF 1 05 1
0100 0EFF 3 03 1
0400 07FF 4 03 1

//--- flist.f
design/axi_lite_pkg.sv
design/traffic_pkg.sv
design/rd_master_ifs.sv
design/lfsr32.sv
design/ar_request_gen.sv
design/rd_or_table.sv
design/r_completion_checker.sv
design/rd_traffic_master.sv
sim/tb_rd_traffic_master.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the read traffic master testbench with Verilator
set -e

verilator --binary --timing --assert -j 0 \
    --top-module tb_rd_traffic_master \
    -f flist.f -o sim_tb

./obj_dir/sim_tb > sim.log
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
